// ==== test/decoder_cases.txt ====
// Columns: address, htrans (0 IDLE 1 BUSY 2 NONSEQ 3 SEQ), sel_dec, hreadys,
// expected address-phase port (0 to 5 for MI0 to MI5, 8 for the default slave)
00000000 2 1 1 0
000FFFFF 2 1 1 0
00100000 2 1 1 8
20000000 2 1 1 1
200FFFFF 3 1 1 1
20100000 0 1 1 1
40000000 2 1 1 2
40005FFF 3 1 1 2
40006000 2 1 1 8
40010000 2 1 1 3
40010FFF 2 1 1 3
40011000 2 1 1 4
40015FFF 3 1 1 4
40016000 0 1 1 4
40016000 2 1 1 8
40008000 2 1 1 5
400083FF 3 1 1 5
40008400 1 1 1 8
40008400 0 1 1 8
00100000 2 0 1 8
40000000 2 0 1 2
20000400 3 1 0 1
FFFFFC00 2 1 1 8
000FFC00 0 1 1 0
40005C00 2 1 1 2
80000000 0 1 1 2
40010400 2 1 1 3

// ==== ahb_decoder_stage.f ====
logic/ahb_pkg.sv
logic/matrix_map_pkg.sv
logic/addr_decode_stage.sv
logic/data_phase_stage.sv
logic/default_slave.sv
logic/ahb_decoder_stage.sv
test/decoder_properties.sv
test/decoder_checker.sv
test/tb_ahb_decoder_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert \
    -f ahb_decoder_stage.f \
    --top-module tb_ahb_decoder_stage \
    -o sim_decoder 2>&1 | tee build.log \
    && ./obj_dir/sim_decoder 2>&1 | tee sim.log \
    || { echo "Build or simulation aborted"; exit 1; }

# Verdict from the simulation log
grep -q "=== FAIL ===" sim.log && { echo "Testbench reported failure"; exit 1; } \
    || grep -q "=== PASS ===" sim.log \
    || { echo "No verdict found in sim.log"; exit 1; }

echo "Simulation run finished cleanly"

// ==== test/tb_ahb_decoder_stage.sv ====
module tb_ahb_decoder_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import ahb_pkg::*;
    import matrix_map_pkg::*;

    localparam int MAX_CASES   = 64;
    localparam int STALL_LIMIT = 32;    // Cycles allowed with hreadyouts low

    logic                  HCLK = 1'b0;
    logic                  HRESETn;
    logic                  hreadys;
    logic                  sel_dec;
    logic [21:0]           decode_addr_dec;
    htrans_t               trans_dec;
    logic [NUM_PORTS-1:0]  active_in;
    logic [NUM_PORTS-1:0]  readyout_in;
    hresp_t                resp_in [NUM_PORTS];
    logic [31:0]           rdata_in [NUM_PORTS];
    logic [NUM_PORTS-1:0]  sel_out;
    logic                  active_dec;
    logic                  hreadyouts;
    hresp_t                hresps;
    logic [31:0]           hrdatas;
    logic                  case_valid;
    logic [3:0]            exp_port;
    int                    err_count;
    int                    timeouts;
    integer                seed;
    logic [31:0]           case_mem [MAX_CASES*5];  // Five words per case line

    always #50 HCLK = ~HCLK;

    ahb_decoder_stage #(.DATA_WIDTH(DATA_WIDTH_DEF)) u_dut (.*);

    decoder_checker #(.DATA_WIDTH(DATA_WIDTH_DEF)) u_chk (.*);

    bind ahb_decoder_stage decoder_properties u_props (
        .HCLK(HCLK), .HRESETn(HRESETn), .sel_dec(sel_dec), .sel_out(sel_out),
        .dft_readyout(dft_readyout), .dft_resp(dft_resp), .hresps(hresps)
    );

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------

    task drive_idle();
        sel_dec    = 1'b0;
        trans_dec  = HTRANS_IDLE;
        hreadys    = 1'b0;                          // Wait state
        case_valid = 1'b0;
    endtask

    // Random switch-side inputs with readyout high three times in four
    task randomize_ports(input bit with_ready);
        integer r;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            r              = $random(seed);
            active_in[i]   = r[0];
            resp_in[i]     = hresp_t'(r[2:1]);
            rdata_in[i]    = $random(seed);
            if (with_ready)
                readyout_in[i] = (r[4:3] != 2'b00);
        end
    endtask

    // Stalls from a falling edge until the owner is ready
    task wait_ready(output bit ok);
        int n;
        n = 0;
        while (!hreadyouts && n < STALL_LIMIT)
        begin
            drive_idle();
            randomize_ports(1'b1);
            @(negedge HCLK);
            n++;
        end
        ok = hreadyouts;
    endtask

    task apply_case(input int idx);
        decode_addr_dec = case_mem[5*idx][31:10];
        trans_dec       = htrans_t'(case_mem[5*idx+1][1:0]);
        sel_dec         = case_mem[5*idx+2][0];
        hreadys         = case_mem[5*idx+3][0];
        exp_port        = case_mem[5*idx+4][3:0];
        case_valid      = 1'b1;
        randomize_ports(!hreadys);                  // Owner keeps ready while hreadys high
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial
    begin
        bit ok;
        bit aborted;
        HRESETn         = 1'b0;
        drive_idle();
        decode_addr_dec = '0;
        active_in       = '0;
        readyout_in     = '1;
        exp_port        = '0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            resp_in[i]  = HRESP_OKAY;
            rdata_in[i] = '0;
        end
        timeouts = 0;
        aborted  = 1'b0;
        seed     = 51107;
        for (int k = 0; k < MAX_CASES*5; k++)
            case_mem[k] = ~k;                       // Words past the file hold a port code above 8
        $readmemh("test/decoder_cases.txt", case_mem);
        repeat (5) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;
        for (int i = 0; i < MAX_CASES && !aborted; i++)
        begin
            if (case_mem[5*i+4] > 32'd8)
                break;                              // End of case file
            @(negedge HCLK);
            wait_ready(ok);
            if (!ok)
            begin
                $display("Timeout at %0t ns: hreadyouts stayed low before case %0d", $time, i);
                timeouts++;
                aborted = 1'b1;
            end
            else
                apply_case(i);
        end
        if (!aborted)
        begin
            @(negedge HCLK);
            wait_ready(ok);                         // Let a last error sequence finish
            if (!ok)
            begin
                $display("Timeout at %0t ns: hreadyouts stayed low after the last case", $time);
                timeouts++;
            end
            drive_idle();
            repeat (2) @(posedge HCLK);
        end
        $display("Value errors: %0d, timeouts: %0d", err_count, timeouts);
        if (err_count == 0 && timeouts == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== test/decoder_checker.sv ====
module decoder_checker #(
    parameter int DATA_WIDTH = ahb_pkg::DATA_WIDTH_DEF
) (
    input  logic                                       HCLK,
    input  logic                                       HRESETn,
    input  logic                                       hreadys,
    input  logic                                       sel_dec,
    input  logic [ahb_pkg::ADDR_MSB:ahb_pkg::ADDR_LSB] decode_addr_dec,
    input  ahb_pkg::htrans_t                           trans_dec,
    input  logic [matrix_map_pkg::NUM_PORTS-1:0]       active_in,
    input  logic [matrix_map_pkg::NUM_PORTS-1:0]       readyout_in,
    input  ahb_pkg::hresp_t                            resp_in [matrix_map_pkg::NUM_PORTS],
    input  logic [DATA_WIDTH-1:0]                      rdata_in [matrix_map_pkg::NUM_PORTS],
    input  logic                                       case_valid,  // Case line applied
    input  logic [3:0]                                 exp_port,    // From the case file
    input  logic [matrix_map_pkg::NUM_PORTS-1:0]       sel_out,
    input  logic                                       active_dec,
    input  logic                                       hreadyouts,
    input  ahb_pkg::hresp_t                            hresps,
    input  logic [DATA_WIDTH-1:0]                      hrdatas,
    output int                                         err_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import ahb_pkg::*;
    import matrix_map_pkg::*;

    // Byte address map, straight from the region list
    localparam logic [31:0] MAP_LO [6] = '{32'h00000000, 32'h20000000, 32'h40000000,
                                          32'h40010000, 32'h40011000, 32'h40008000};
    localparam logic [31:0] MAP_HI [6] = '{32'h000FFFFF, 32'h200FFFFF, 32'h40005FFF,
                                          32'h40010FFF, 32'h40015FFF, 32'h400083FF};

    int                    errs = 0;
    int                    owner;       // Model data-phase owner, 8 = default slave
    int                    mp;          // Model address-phase port
    logic                  ds_err1;     // Ready-low error cycle
    logic                  ds_err2;     // Ready-high error cycle
    logic [NUM_PORTS-1:0]  exp_sel;
    logic                  exp_active;
    logic                  exp_ready;
    hresp_t                exp_resp;
    logic [DATA_WIDTH-1:0] exp_rdata;

    assign err_count = errs;

    // First region hit wins, an IDLE may stay with the owner
    function automatic int model_port(logic [21:0] addr, htrans_t tr, int own);
        logic [31:0] full;
        int          result;
        full   = {addr, 10'h000};
        result = 8;
        for (int i = 0; i < 6; i++)
        begin
            if (result == 8 && ((full >= MAP_LO[i] && full <= MAP_HI[i]) ||
                                (tr == HTRANS_IDLE && own == i)))
            begin
                result = i;
            end
        end
        return result;
    endfunction

    task automatic fail_check(string what);
        $display("Fail at %0t ns: %s", $time, what);
        errs++;
    endtask

    // --------------------------------------------------
    // Compare on every rising edge
    // --------------------------------------------------

    always @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            owner   <= 0;
            ds_err1 <= 1'b0;
            ds_err2 <= 1'b0;
        end
        else
        begin
            mp = model_port(decode_addr_dec, trans_dec, owner);
            exp_active = 1'b1;                      // Default slave always active
            for (int i = 0; i < NUM_PORTS; i++)
            begin
                exp_sel[i] = sel_dec && (mp == i);
                if (mp == i)
                    exp_active = active_in[i];
            end
            exp_ready = !ds_err1;
            exp_resp  = (ds_err1 || ds_err2) ? HRESP_ERROR : HRESP_OKAY;
            exp_rdata = '0;
            for (int i = 0; i < NUM_PORTS; i++)
            begin
                if (owner == i)
                begin
                    exp_ready = readyout_in[i];
                    exp_resp  = resp_in[i];
                    exp_rdata = rdata_in[i];
                end
            end
            if (case_valid && mp != int'(exp_port))
                fail_check($sformatf("model port %0d, case file expects %0d", mp, exp_port));
            if (sel_out !== exp_sel)
                fail_check($sformatf("sel_out %b, expected %b", sel_out, exp_sel));
            if (active_dec !== exp_active)
                fail_check($sformatf("active_dec %b, expected %b", active_dec, exp_active));
            if (hreadyouts !== exp_ready || hresps !== exp_resp)
                fail_check($sformatf("ready/resp %b/%0d, expected %b/%0d (owner %0d)",
                                     hreadyouts, hresps, exp_ready, exp_resp, owner));
            if (hrdatas !== exp_rdata)
                fail_check($sformatf("hrdatas %h, expected %h", hrdatas, exp_rdata));
            if (hreadys)
                owner <= mp;                        // Address phase completes
            ds_err2 <= ds_err1;
            ds_err1 <= sel_dec && hreadys && (mp == 8) &&
                       (trans_dec == HTRANS_NONSEQ || trans_dec == HTRANS_SEQ);
        end
    end

endmodule

// ==== test/decoder_properties.sv ====
module decoder_properties (
    input logic                                 HCLK,
    input logic                                 HRESETn,
    input logic                                 sel_dec,
    input logic [matrix_map_pkg::NUM_PORTS-1:0] sel_out,
    input logic                                 dft_readyout,
    input ahb_pkg::hresp_t                      dft_resp,
    input ahb_pkg::hresp_t                      hresps
);
    timeunit 1ns;
    timeprecision 1ps;
    import ahb_pkg::*;

    // --------------------------------------------------
    // Select outputs
    // --------------------------------------------------

    a_sel_onehot0: assert property (@(posedge HCLK) disable iff (!HRESETn)
        $onehot0(sel_out))
        else $error("More than one sel_out bit is high");

    a_sel_gated: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !sel_dec |-> (sel_out == '0))
        else $error("A sel_out bit is high while sel_dec is low");

    // --------------------------------------------------
    // Default slave error sequence
    // --------------------------------------------------

    // First error cycle must be followed by the ready-high one
    a_err_two_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (dft_resp == HRESP_ERROR && !dft_readyout) |=>
        (dft_resp == HRESP_ERROR && dft_readyout))
        else $error("Default slave error response did not finish with ready high");

    // Bus OKAY and default slave idle once reset lifts
    a_okay_after_reset: assert property (@(posedge HCLK)
        $rose(HRESETn) |->
        (hresps == HRESP_OKAY && dft_resp == HRESP_OKAY && dft_readyout))
        else $error("Response is not OKAY with ready high right after reset");

endmodule

// ==== logic/ahb_decoder_stage.sv ====
module ahb_decoder_stage #(
    parameter int DATA_WIDTH = ahb_pkg::DATA_WIDTH_DEF
) (
    input  logic                                       HCLK,
    input  logic                                       HRESETn,

    // From the input stage
    input  logic                                       hreadys,         // Transfer done
    input  logic                                       sel_dec,         // HSEL in
    input  logic [ahb_pkg::ADDR_MSB:ahb_pkg::ADDR_LSB] decode_addr_dec,
    input  ahb_pkg::htrans_t                           trans_dec,

    // From the bus switches, one entry per MI port
    input  logic [matrix_map_pkg::NUM_PORTS-1:0]       active_in,
    input  logic [matrix_map_pkg::NUM_PORTS-1:0]       readyout_in,
    input  ahb_pkg::hresp_t                            resp_in [matrix_map_pkg::NUM_PORTS],
    input  logic [DATA_WIDTH-1:0]                      rdata_in [matrix_map_pkg::NUM_PORTS],

    // To the bus switches
    output logic [matrix_map_pkg::NUM_PORTS-1:0]       sel_out,         // HSEL per port

    // Back to the input stage
    output logic                                       active_dec,
    output logic                                       hreadyouts,
    output ahb_pkg::hresp_t                            hresps,
    output logic [DATA_WIDTH-1:0]                      hrdatas
);
    import ahb_pkg::*;
    import matrix_map_pkg::*;

    port_t  addr_port;          // Address-phase port
    port_t  data_port;          // Data-phase owner
    logic   dft_sel;
    logic   dft_readyout;
    hresp_t dft_resp;

    // --------------------------------------------------
    // Address phase
    // --------------------------------------------------

    addr_decode_stage u_addr_decode (
        .sel_dec         (sel_dec),
        .decode_addr_dec (decode_addr_dec),
        .trans_dec       (trans_dec),
        .data_port       (data_port),       // Idle hold feedback
        .active_in       (active_in),
        .addr_port       (addr_port),
        .sel_out         (sel_out),
        .dft_sel         (dft_sel),
        .active_dec      (active_dec)
    );

    // --------------------------------------------------
    // Data phase and default slave
    // --------------------------------------------------

    data_phase_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_data_phase (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .hreadys      (hreadys),
        .addr_port    (addr_port),
        .readyout_in  (readyout_in),
        .resp_in      (resp_in),
        .rdata_in     (rdata_in),
        .dft_readyout (dft_readyout),
        .dft_resp     (dft_resp),
        .data_port    (data_port),
        .hreadyouts   (hreadyouts),
        .hresps       (hresps),
        .hrdatas      (hrdatas)
    );

    // Answers unmapped accesses
    default_slave u_default_slave (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .dft_sel      (dft_sel),
        .trans_dec    (trans_dec),
        .hreadys      (hreadys),
        .dft_readyout (dft_readyout),
        .dft_resp     (dft_resp)
    );

endmodule

// ==== logic/default_slave.sv ====
module default_slave (
    input  logic             HCLK,
    input  logic             HRESETn,
    input  logic             dft_sel,
    input  ahb_pkg::htrans_t trans_dec,
    input  logic             hreadys,
    output logic             dft_readyout,
    output ahb_pkg::hresp_t  dft_resp
);
    import ahb_pkg::*;
    import matrix_map_pkg::*;

    DS_STATE_T ds_state;
    DS_STATE_T ds_state_nxt;
    logic      err_first;       // First error cycle, ready low
    logic      trans_req;       // Real transfer accepted into unmapped space

    // IDLE and BUSY get OKAY with no waits
    assign trans_req = dft_sel && hreadys &&
                       ((trans_dec == HTRANS_NONSEQ) || (trans_dec == HTRANS_SEQ));

    // --------------------------------------------------
    // Error sequence FSM
    // --------------------------------------------------

    always_comb
    begin
        ds_state_nxt = ds_state;
        case (ds_state)
            DS_IDLE:
            begin
                if (err_first)
                begin
                    ds_state_nxt = DS_ERR2;         // Ready goes high next
                end
            end
            DS_ERR2:
            begin
                ds_state_nxt = DS_IDLE;             // Sequence done
            end
        endcase
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            ds_state  <= DS_IDLE;
            err_first <= 1'b0;
        end
        else
        begin
            ds_state  <= ds_state_nxt;
            err_first <= trans_req;                 // Low again while hreadys low
        end
    end

    // Ready low only in the first error cycle
    assign dft_readyout = ~err_first;
    assign dft_resp     = (err_first || (ds_state == DS_ERR2)) ? HRESP_ERROR : HRESP_OKAY;

endmodule

// ==== logic/data_phase_stage.sv ====
module data_phase_stage #(
    parameter int DATA_WIDTH = ahb_pkg::DATA_WIDTH_DEF
) (
    input  logic                                 HCLK,
    input  logic                                 HRESETn,
    input  logic                                 hreadys,
    input  matrix_map_pkg::port_t                addr_port,

    // Per-port response side
    input  logic [matrix_map_pkg::NUM_PORTS-1:0] readyout_in,
    input  ahb_pkg::hresp_t                      resp_in [matrix_map_pkg::NUM_PORTS],
    input  logic [DATA_WIDTH-1:0]                rdata_in [matrix_map_pkg::NUM_PORTS],

    // Default slave response
    input  logic                                 dft_readyout,
    input  ahb_pkg::hresp_t                      dft_resp,

    output matrix_map_pkg::port_t                data_port,
    output logic                                 hreadyouts,
    output ahb_pkg::hresp_t                      hresps,
    output logic [DATA_WIDTH-1:0]                hrdatas
);
    import matrix_map_pkg::*;

    // --------------------------------------------------
    // Data-phase owner
    // --------------------------------------------------

    // Loads on every completed address phase
    // hreadys, not hreadyouts, so a stalled owner keeps the bus
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            data_port <= PORT_MI0;                  // Reset owner
        end
        else if (hreadys)
        begin
            data_port <= addr_port;
        end
        // hreadys low: wait states, hold
    end

    // --------------------------------------------------
    // Response muxes
    // --------------------------------------------------

    // Default slave values first, a matching MI port overrides
    always_comb
    begin
        hreadyouts = dft_readyout;
        hresps     = dft_resp;
        hrdatas    = '0;                            // Default slave reads zero
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (data_port == port_t'(4'(i)))
            begin
                hreadyouts = readyout_in[i];        // Back-pressure passes straight
                hresps     = resp_in[i];
                hrdatas    = rdata_in[i];
            end
        end
    end

endmodule

// ==== logic/addr_decode_stage.sv ====
module addr_decode_stage (
    input  logic                                       sel_dec,
    input  logic [ahb_pkg::ADDR_MSB:ahb_pkg::ADDR_LSB] decode_addr_dec,
    input  ahb_pkg::htrans_t                           trans_dec,
    input  matrix_map_pkg::port_t                      data_port,
    input  logic [matrix_map_pkg::NUM_PORTS-1:0]       active_in,
    output matrix_map_pkg::port_t                      addr_port,
    output logic [matrix_map_pkg::NUM_PORTS-1:0]       sel_out,
    output logic                                       dft_sel,
    output logic                                       active_dec
);
    import ahb_pkg::*;
    import matrix_map_pkg::*;

    logic [NUM_PORTS-1:0] region_hit;   // Address inside the port region
    logic [NUM_PORTS-1:0] hold_hit;     // IDLE stays with data-phase owner
    logic                 trans_idle;

    assign trans_idle = (trans_dec == HTRANS_IDLE);

    // --------------------------------------------------
    // Region compare
    // --------------------------------------------------

    // One comparator pair per port, bounds from the map package
    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            region_hit[i] = (decode_addr_dec >= REGION_LO[i]) &&
                            (decode_addr_dec <= REGION_HI[i]);
            hold_hit[i]   = trans_idle && (data_port == port_t'(4'(i)));
        end
    end

    // Priority MI0 first, walk down so the lowest hit is left standing
    always_comb
    begin
        addr_port = PORT_DFT;                       // Nothing matched
        for (int i = NUM_PORTS - 1; i >= 0; i--)
        begin
            if (region_hit[i] || hold_hit[i])
            begin
                addr_port = port_t'(4'(i));
            end
        end
    end

    // --------------------------------------------------
    // Selects and active flag
    // --------------------------------------------------

    // At most one select, none without sel_dec
    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            sel_out[i] = sel_dec && (addr_port == port_t'(4'(i)));
        end
    end

    assign dft_sel = sel_dec && (addr_port == PORT_DFT);  // Error responder

    // Active of the addressed port
    always_comb
    begin
        active_dec = 1'b1;                          // Default slave never busy
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (addr_port == port_t'(4'(i)))
            begin
                active_dec = active_in[i];
            end
        end
    end

endmodule

// ==== logic/matrix_map_pkg.sv ====
package matrix_map_pkg;

    // --------------------------------------------------
    // Output ports of the slave interface
    // --------------------------------------------------

    localparam int NUM_PORTS = 6;   // MI0 to MI5

    // Port code, default slave sits apart at 8
    typedef enum logic [3:0] {
        PORT_MI0 = 4'd0,
        PORT_MI1 = 4'd1,
        PORT_MI2 = 4'd2,
        PORT_MI3 = 4'd3,
        PORT_MI4 = 4'd4,
        PORT_MI5 = 4'd5,
        PORT_DFT = 4'd8             // Unmapped space
    } port_t;

    // --------------------------------------------------
    // Address map in HADDR[31:10] units
    // --------------------------------------------------

    // Inclusive bounds, index is the port number
    localparam logic [ahb_pkg::ADDR_MSB:ahb_pkg::ADDR_LSB] REGION_LO [NUM_PORTS] = '{
        22'h000000,                 // MI0 0x00000000
        22'h080000,                 // MI1 0x20000000
        22'h100000,                 // MI2 0x40000000
        22'h100040,                 // MI3 0x40010000
        22'h100044,                 // MI4 0x40011000
        22'h100020                  // MI5 0x40008000
    };

    localparam logic [ahb_pkg::ADDR_MSB:ahb_pkg::ADDR_LSB] REGION_HI [NUM_PORTS] = '{
        22'h0003ff,                 // MI0 0x000FFFFF
        22'h0803ff,                 // MI1 0x200FFFFF
        22'h100017,                 // MI2 0x40005FFF
        22'h100043,                 // MI3 0x40010FFF
        22'h100057,                 // MI4 0x40015FFF
        22'h100020                  // MI5 0x400083FF, one 1 KB page
    };

    // Default slave FSM
    typedef enum logic {
        DS_IDLE = 1'b0,             // OKAY, or first error cycle pending
        DS_ERR2 = 1'b1              // Second error cycle, ready high
    } DS_STATE_T;

endpackage

// ==== logic/ahb_pkg.sv ====
package ahb_pkg;

    // --------------------------------------------------
    // Transfer type and response encodings
    // --------------------------------------------------

    // HTRANS as seen by the decoder
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,      // No transfer wanted
        HTRANS_BUSY   = 2'b01,      // Master stalls mid-burst
        HTRANS_NONSEQ = 2'b10,      // Single or first beat
        HTRANS_SEQ    = 2'b11       // Following burst beats
    } htrans_t;

    // HRESP, AHB2 style with retry and split
    typedef enum logic [1:0] {
        HRESP_OKAY  = 2'b00,
        HRESP_ERROR = 2'b01,        // Two-cycle error
        HRESP_RETRY = 2'b10,
        HRESP_SPLIT = 2'b11
    } hresp_t;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------

    // Decoded slice of HADDR, 1 KB granularity
    localparam int ADDR_MSB = 31;
    localparam int ADDR_LSB = 10;   // 22-bit field

    // Read data bus, top level may widen it
    localparam int DATA_WIDTH_DEF = 32;

endpackage
